// ==== rtl/pov_display_settings.svh ====
// POV display sizes and timing
`ifndef POV_DISPLAY_SETTINGS_SVH
`define POV_DISPLAY_SETTINGS_SVH

// Number of LED driver serial lines
`define POV_NUM_DRIVERS 4

// Bits shifted into each driver per frame
`define POV_WORD_BITS 48

// Columns on the rotor
`define POV_NUM_COLUMNS 8

// Clk cycles per shift tick
`define POV_SHIFT_DIV 4

// Clk cycles per gray-scale clock half period
`define POV_GCLK_DIV 2

// Config latch length in ticks
`define POV_CFG_LATCH_TICKS 3

// SPI input synchronizer depth
`define POV_SYNC_STAGES 2

`endif

// ==== rtl/pov_display_pkg.sv ====
// POV display shared types
`include "pov_display_settings.svh"

package pov_display_pkg;

    // Host command opcodes, first byte of every SPI frame
    typedef enum logic [7:0] {
        WRITE_COLUMN  = 8'h01,
        WRITE_CONFIG  = 8'h02,
        SET_MUX       = 8'h03,
        READ_ROTATION = 8'h04
    } opcode_t;

    // Driver sequencer states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        SHIFT,
        LATCH,
        ADVANCE
    } seq_state_t;

    // One serial word for one driver
    typedef logic [`POV_WORD_BITS-1:0] driver_word_t;

    // Decoded SPI frame, 72 bits
    typedef struct packed {
        opcode_t      opcode;
        logic [7:0]   index;
        driver_word_t payload;
        logic [7:0]   byte_count;
    } spi_cmd_t;

    // Shared driver pins plus one data line per driver
    typedef struct packed {
        logic                        sclk;
        logic                        gclk;
        logic                        lat;
        logic [`POV_NUM_DRIVERS-1:0] sin;
    } drv_bus_t;

    // One bit per column
    typedef logic [`POV_NUM_COLUMNS-1:0] column_mask_t;

endpackage

// ==== rtl/spi_command_receiver.sv ====
// SPI command receiver
`timescale 1ns/1ns
`include "pov_display_settings.svh"

module spi_command_receiver (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      spi_sclk,
    input  logic                      spi_cs_n,
    input  logic                      spi_mosi,
    output logic                      spi_miso,
    input  logic [15:0]               rotation,
    output pov_display_pkg::spi_cmd_t cmd,
    output logic                      cmd_valid
);
    localparam int S = `POV_SYNC_STAGES;

    // Top bit of sclk and cs chains holds the previous synced value
    logic [S:0]   sclk_q;
    logic [S:0]   cs_q;
    logic [S-1:0] mosi_q;
    logic         sclk_rise;
    logic         sclk_fall;
    logic         cs_rise;
    logic         cs_fall;
    logic         cs_active;
    logic [2:0]   bit_cnt;
    logic [7:0]   byte_cnt;
    logic [6:0]   shift_in;
    logic [7:0]   rx_byte;
    logic [7:0]   opcode;
    logic [7:0]   index;
    logic [15:0]  miso_shift;
    pov_display_pkg::driver_word_t payload;

    // Edge detect on the synced pins
    assign sclk_rise = sclk_q[S-1] & ~sclk_q[S];
    assign sclk_fall = ~sclk_q[S-1] & sclk_q[S];
    assign cs_rise   = cs_q[S-1] & ~cs_q[S];
    assign cs_fall   = ~cs_q[S-1] & cs_q[S];
    assign cs_active = ~cs_q[S-1];

    // Byte including the bit arriving now, MSB first
    assign rx_byte = {shift_in, mosi_q[S-1]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sclk_q <= '0;
            // Idle high so reset release gives no false frame end
            cs_q   <= '1;
            mosi_q <= '0;
        end else begin
            sclk_q <= {sclk_q[S-1:0], spi_sclk};
            cs_q   <= {cs_q[S-1:0], spi_cs_n};
            mosi_q <= {mosi_q[S-2:0], spi_mosi};
        end
    end

    // Bit and byte counters, MISO readback shifter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            miso_shift <= '0;
            spi_miso   <= 1'b0;
        end else if (cs_fall) begin
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            miso_shift <= '0;
            spi_miso   <= 1'b0;
        end else if (cs_active && sclk_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                byte_cnt <= byte_cnt + 8'd1;
                // Rotation snapshot taken as soon as the opcode completes
                if (byte_cnt == 8'd0 && rx_byte == pov_display_pkg::READ_ROTATION) begin
                    miso_shift <= rotation;
                end
            end
        end else if (cs_active && sclk_fall) begin
            // Mode 0, host samples on the following rising edge
            spi_miso   <= miso_shift[15];
            miso_shift <= {miso_shift[14:0], 1'b0};
        end
    end

    // Frame fields
    always_ff @(posedge clk) begin
        if (cs_fall) begin
            index   <= '0;
            payload <= '0;
        end else if (cs_active && sclk_rise) begin
            shift_in <= rx_byte[6:0];
            if (bit_cnt == 3'd7) begin
                if (byte_cnt == 8'd0) begin
                    opcode <= rx_byte;
                end else if (byte_cnt == 8'd1 && opcode == pov_display_pkg::WRITE_COLUMN) begin
                    index <= rx_byte;
                end else begin
                    // Right aligned, the last bytes win
                    payload <= {payload[`POV_WORD_BITS-9:0], rx_byte};
                end
            end
        end
        if (cs_rise) begin
            cmd.opcode     <= pov_display_pkg::opcode_t'(opcode);
            cmd.index      <= index;
            cmd.payload    <= payload;
            cmd.byte_count <= byte_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= cs_rise;
        end
    end

    // One strobe per frame
    assert property (@(posedge clk) disable iff (!rst_n) cmd_valid |=> !cmd_valid);

endmodule

// ==== rtl/command_decoder.sv ====
// SPI command decoder
`timescale 1ns/1ns
`include "pov_display_settings.svh"

module command_decoder (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  pov_display_pkg::spi_cmd_t             cmd,
    input  logic                                  cmd_valid,
    output logic                                  buf_we,
    output logic [$clog2(`POV_NUM_DRIVERS)-1:0]   buf_index,
    output pov_display_pkg::driver_word_t         buf_data,
    output pov_display_pkg::driver_word_t         cfg_word,
    output logic                                  cfg_pending,
    input  logic                                  cfg_taken,
    output pov_display_pkg::column_mask_t         mask
);
    localparam int IW         = $clog2(`POV_NUM_DRIVERS);
    localparam int WORD_BYTES = `POV_WORD_BITS / 8;

    logic col_ok;
    logic cfg_ok;
    logic mux_ok;

    // Opcode plus minimum byte count per command
    always_comb begin
        col_ok = cmd_valid && cmd.opcode == pov_display_pkg::WRITE_COLUMN &&
                 cmd.byte_count >= 8'(WORD_BYTES + 2) && cmd.index < `POV_NUM_DRIVERS;
        cfg_ok = cmd_valid && cmd.opcode == pov_display_pkg::WRITE_CONFIG &&
                 cmd.byte_count >= 8'(WORD_BYTES + 1);
        mux_ok = cmd_valid && cmd.opcode == pov_display_pkg::SET_MUX &&
                 cmd.byte_count >= 8'd2;
    end

    // Column write toward the buffer, one cycle after the command
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_we <= 1'b0;
        end else begin
            buf_we <= col_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (col_ok) begin
            buf_index <= cmd.index[IW-1:0];
            buf_data  <= cmd.payload;
        end
    end

    // Config word and mask registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_word    <= '0;
            cfg_pending <= 1'b0;
            mask        <= '0;
        end else begin
            if (cfg_ok) begin
                cfg_word <= cmd.payload;
            end
            // New config beats a take in the same cycle
            if (cfg_ok) begin
                cfg_pending <= 1'b1;
            end else if (cfg_taken) begin
                cfg_pending <= 1'b0;
            end
            if (mux_ok) begin
                mask <= cmd.payload[`POV_NUM_COLUMNS-1:0];
            end
        end
    end

    // Buffer index of a write is the whole host index, never an aliased one
    assert property (@(posedge clk) disable iff (!rst_n)
        buf_we |-> $past(cmd.index) == 8'(buf_index));

endmodule

// ==== rtl/column_buffer.sv ====
// Driver column word buffer
`timescale 1ns/1ns
`include "pov_display_settings.svh"

module column_buffer (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                we,
    input  logic [$clog2(`POV_NUM_DRIVERS)-1:0] index,
    input  pov_display_pkg::driver_word_t       data,
    output pov_display_pkg::driver_word_t       words [`POV_NUM_DRIVERS]
);

    // One word per driver, all read in parallel by the sequencer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `POV_NUM_DRIVERS; i++) begin
                words[i] <= '0;
            end
        end else if (we) begin
            words[index] <= data;
        end
    end

endmodule

// ==== rtl/driver_sequencer.sv ====
// LED driver shift sequencer
`timescale 1ns/1ns
`include "pov_display_settings.svh"

module driver_sequencer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          position_sync,
    input  logic                          cfg_pending,
    input  pov_display_pkg::driver_word_t cfg_word,
    input  pov_display_pkg::driver_word_t words [`POV_NUM_DRIVERS],
    input  logic                          tick,
    input  logic                          bits_done,
    output logic                          timer_run,
    output logic                          cfg_taken,
    output pov_display_pkg::drv_bus_t     drv,
    output logic                          column_ready
);
    localparam int W  = `POV_WORD_BITS;
    localparam int LW = $clog2(`POV_CFG_LATCH_TICKS);

    pov_display_pkg::seq_state_t   state;
    logic                          cfg_frame;
    logic [LW-1:0]                 latch_cnt;
    logic [LW-1:0]                 latch_last;
    pov_display_pkg::driver_word_t sreg [`POV_NUM_DRIVERS];

    // Config latch is longer than the data latch
    assign latch_last = cfg_frame ? LW'(`POV_CFG_LATCH_TICKS - 1) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= pov_display_pkg::IDLE;
            cfg_frame <= 1'b0;
            latch_cnt <= '0;
        end else begin
            case (state)
                pov_display_pkg::IDLE: begin
                    // Pulses outside IDLE are dropped
                    if (position_sync) begin
                        cfg_frame <= cfg_pending;
                        state     <= pov_display_pkg::LOAD;
                    end
                end
                pov_display_pkg::LOAD: begin
                    latch_cnt <= '0;
                    state     <= pov_display_pkg::SHIFT;
                end
                pov_display_pkg::SHIFT: begin
                    if (bits_done) begin
                        state <= pov_display_pkg::LATCH;
                    end
                end
                pov_display_pkg::LATCH: begin
                    if (tick) begin
                        if (latch_cnt == latch_last) begin
                            // Data frame follows a config frame without a pulse
                            if (cfg_frame) begin
                                cfg_frame <= 1'b0;
                                state     <= pov_display_pkg::LOAD;
                            end else begin
                                state <= pov_display_pkg::ADVANCE;
                            end
                        end else begin
                            latch_cnt <= latch_cnt + 1'b1;
                        end
                    end
                end
                pov_display_pkg::ADVANCE: begin
                    state <= pov_display_pkg::IDLE;
                end
                default: begin
                    state <= pov_display_pkg::IDLE;
                end
            endcase
        end
    end

    // Per-driver shift registers, MSB on the line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `POV_NUM_DRIVERS; i++) begin
                sreg[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `POV_NUM_DRIVERS; i++) begin
                if (state == pov_display_pkg::LOAD) begin
                    sreg[i] <= cfg_frame ? cfg_word : words[i];
                end else if (state == pov_display_pkg::SHIFT && tick) begin
                    sreg[i] <= {sreg[i][W-2:0], 1'b0};
                end
            end
        end
    end

    always_comb begin
        // Sclk pulse samples the bit set on the previous tick
        drv.sclk = (state == pov_display_pkg::SHIFT) && tick;
        // Gray-scale clock comes from the timer at top level
        drv.gclk = 1'b0;
        drv.lat  = (state == pov_display_pkg::LATCH);
        for (int i = 0; i < `POV_NUM_DRIVERS; i++) begin
            drv.sin[i] = sreg[i][W-1];
        end
    end

    assign timer_run    = (state == pov_display_pkg::SHIFT) || (state == pov_display_pkg::LATCH);
    assign cfg_taken    = (state == pov_display_pkg::LOAD) && cfg_frame;
    assign column_ready = (state == pov_display_pkg::ADVANCE);

    assert property (@(posedge clk) disable iff (!rst_n) !(drv.lat && drv.sclk));

endmodule

// ==== rtl/shift_timer.sv ====
// Shift tick and gray-scale clock timer
`timescale 1ns/1ns
`include "pov_display_settings.svh"

module shift_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic tick,
    output logic bits_done,
    output logic gclk
);
    localparam int PW = $clog2(`POV_SHIFT_DIV);
    localparam int GW = $clog2(`POV_GCLK_DIV);

    logic [PW-1:0] prescale;
    logic [5:0]    bit_cnt;
    logic [GW-1:0] gclk_cnt;

    assign tick = run && (prescale == PW'(`POV_SHIFT_DIV - 1));

    // High on the tick of the last bit
    assign bits_done = tick && (bit_cnt == 6'(`POV_WORD_BITS - 1));

    // Prescaler and bit count restart whenever run drops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prescale <= '0;
            bit_cnt  <= '0;
        end else if (!run) begin
            prescale <= '0;
            bit_cnt  <= '0;
        end else begin
            prescale <= tick ? '0 : prescale + 1'b1;
            if (tick) begin
                bit_cnt <= bit_cnt + 6'd1;
            end
        end
    end

    // Free running gray-scale clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gclk_cnt <= '0;
            gclk     <= 1'b0;
        end else if (gclk_cnt == GW'(`POV_GCLK_DIV - 1)) begin
            gclk_cnt <= '0;
            gclk     <= ~gclk;
        end else begin
            gclk_cnt <= gclk_cnt + 1'b1;
        end
    end

endmodule

// ==== rtl/column_selector.sv ====
// Rotating column selector
`timescale 1ns/1ns
`include "pov_display_settings.svh"

module column_selector (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          column_ready,
    input  pov_display_pkg::column_mask_t mask,
    output pov_display_pkg::column_mask_t column_sel
);
    pov_display_pkg::column_mask_t pointer;

    // One-hot pointer starting at column 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pointer <= pov_display_pkg::column_mask_t'(1);
        end else if (column_ready) begin
            // Wrap from last column back to column 0
            pointer <= {pointer[`POV_NUM_COLUMNS-2:0], pointer[`POV_NUM_COLUMNS-1]};
        end
    end

    // Disabled columns stay dark
    assign column_sel = pointer & mask;

    assert property (@(posedge clk) disable iff (!rst_n) $onehot(pointer));

endmodule

// ==== rtl/pov_display_top.sv ====
// POV display control core
`timescale 1ns/1ns
`include "pov_display_settings.svh"

module pov_display_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          spi_sclk,
    input  logic                          spi_cs_n,
    input  logic                          spi_mosi,
    output logic                          spi_miso,
    input  logic [15:0]                   rotation,
    input  logic                          position_sync,
    output pov_display_pkg::drv_bus_t     drv,
    output pov_display_pkg::column_mask_t column_sel
);
    pov_display_pkg::spi_cmd_t                cmd;
    logic                                     cmd_valid;
    logic                                     buf_we;
    logic [$clog2(`POV_NUM_DRIVERS)-1:0]      buf_index;
    pov_display_pkg::driver_word_t            buf_data;
    pov_display_pkg::driver_word_t            cfg_word;
    logic                                     cfg_pending;
    logic                                     cfg_taken;
    pov_display_pkg::column_mask_t            mask;
    pov_display_pkg::driver_word_t            words [`POV_NUM_DRIVERS];
    logic                                     tick;
    logic                                     bits_done;
    logic                                     timer_run;
    logic                                     gclk;
    logic                                     column_ready;
    pov_display_pkg::drv_bus_t                seq_drv;

    // Host command path
    spi_command_receiver u_spi (
        .clk(clk), .rst_n(rst_n),
        .spi_sclk(spi_sclk), .spi_cs_n(spi_cs_n), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
        .rotation(rotation), .cmd(cmd), .cmd_valid(cmd_valid)
    );

    command_decoder u_dec (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_valid(cmd_valid),
        .buf_we(buf_we), .buf_index(buf_index), .buf_data(buf_data),
        .cfg_word(cfg_word), .cfg_pending(cfg_pending), .cfg_taken(cfg_taken), .mask(mask)
    );

    column_buffer u_buf (
        .clk(clk), .rst_n(rst_n), .we(buf_we), .index(buf_index), .data(buf_data),
        .words(words)
    );

    // Driver shift path
    driver_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .position_sync(position_sync),
        .cfg_pending(cfg_pending), .cfg_word(cfg_word), .words(words),
        .tick(tick), .bits_done(bits_done), .timer_run(timer_run),
        .cfg_taken(cfg_taken), .drv(seq_drv), .column_ready(column_ready)
    );

    shift_timer u_timer (
        .clk(clk), .rst_n(rst_n), .run(timer_run),
        .tick(tick), .bits_done(bits_done), .gclk(gclk)
    );

    column_selector u_col (
        .clk(clk), .rst_n(rst_n), .column_ready(column_ready), .mask(mask),
        .column_sel(column_sel)
    );

    // Timer gray-scale clock replaces the sequencer's unused field
    always_comb begin
        drv      = seq_drv;
        drv.gclk = gclk;
    end

endmodule

// ==== verification/pov_display_tb.sv ====
// POV display core testbench
`timescale 1ns/1ns
`include "pov_display_settings.svh"

module pov_display_tb;
    localparam int W             = `POV_WORD_BITS;
    localparam int ND            = `POV_NUM_DRIVERS;
    localparam int NC            = `POV_NUM_COLUMNS;
    localparam int WORD_BYTES    = `POV_WORD_BITS / 8;
    localparam int SPI_HALF      = 4;
    // Sample edges from an accepted pulse until the FSM is idle again
    localparam int FRAME_CYCLES  = 3 + (`POV_WORD_BITS + 1) * `POV_SHIFT_DIV;
    localparam int WRITE_ROUNDS  = 3;
    localparam int MUX_FRAMES    = 10;
    localparam int ROT_READS     = 3;
    localparam int BURST_PULSES  = 12;
    localparam int SPI_FRAMES    = WRITE_ROUNDS * ND + 2 + ROT_READS;
    localparam int SHIFT_FRAMES  = 1 + WRITE_ROUNDS + 3 + MUX_FRAMES + BURST_PULSES;
    localparam int TIMEOUT       = SPI_FRAMES * 600 + SHIFT_FRAMES * 500 + 2000;

    logic                          clk;
    logic                          rst_n;
    logic                          spi_sclk;
    logic                          spi_cs_n;
    logic                          spi_mosi;
    logic                          spi_miso;
    logic [15:0]                   rotation;
    logic                          position_sync;
    pov_display_pkg::drv_bus_t     drv;
    pov_display_pkg::column_mask_t column_sel;

    // Reference model state
    pov_display_pkg::driver_word_t model_words [ND];
    pov_display_pkg::driver_word_t model_cfg;
    logic                          model_pending;
    pov_display_pkg::column_mask_t model_mask;
    int                            model_col;

    // Frames seen on the driver bus
    pov_display_pkg::driver_word_t cap_word [ND];
    pov_display_pkg::driver_word_t got_words [$];
    int                            got_bits [$];
    int                            got_lat [$];
    int                            bit_count;
    int                            lat_cycles;

    // Gray-scale clock tracking
    logic        gclk_prev;
    int          gclk_run;
    int          gclk_toggles;

    logic [7:0]  tx_bytes [0:7];
    logic [63:0] miso_bits;
    logic [31:0] rng_state;
    int          checks;
    int          errors;
    int          cycle_count;

    pov_display_top UUT (
        .clk(clk), .rst_n(rst_n),
        .spi_sclk(spi_sclk), .spi_cs_n(spi_cs_n), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
        .rotation(rotation), .position_sync(position_sync),
        .drv(drv), .column_sel(column_sel)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT) begin
            $display("timeout after %0d cycles, the DUT stopped producing frames", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Bus monitor, one record per latch pulse
    always @(negedge clk) begin
        if (!rst_n) begin
            bit_count    = 0;
            lat_cycles   = 0;
            gclk_prev    = drv.gclk;
            gclk_run     = 0;
            gclk_toggles = 0;
        end else begin
            if (drv.sclk) begin
                for (int i = 0; i < ND; i++) begin
                    cap_word[i] = {cap_word[i][W-2:0], drv.sin[i]};
                end
                bit_count++;
            end
            if (drv.lat) begin
                lat_cycles++;
            end else if (lat_cycles > 0) begin
                for (int i = 0; i < ND; i++) begin
                    got_words.push_back(cap_word[i]);
                    cap_word[i] = '0;
                end
                got_bits.push_back(bit_count);
                got_lat.push_back(lat_cycles);
                bit_count  = 0;
                lat_cycles = 0;
            end
            // First half period after reset is partial and not measured
            if (drv.gclk !== gclk_prev) begin
                if (gclk_toggles > 0) begin
                    check_half_period(gclk_run, `POV_GCLK_DIV);
                end
                gclk_toggles++;
                gclk_run = 1;
            end else begin
                gclk_run++;
                if (gclk_run == `POV_GCLK_DIV + 1) begin
                    note_failure("drv.gclk stopped toggling");
                end
            end
            gclk_prev = drv.gclk;
        end
    end

    // LCG, upper bits are the useful ones
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic pov_display_pkg::driver_word_t rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo};
    endfunction

    // Lit column from the wheel position and the enable mask
    function automatic pov_display_pkg::column_mask_t expected_columns();
        pov_display_pkg::column_mask_t onehot;
        onehot            = '0;
        onehot[model_col] = 1'b1;
        return onehot & model_mask;
    endfunction

    task automatic note_failure(input string msg);
        errors++;
        $display("%s (at %0t)", msg, $time);
    endtask

    task automatic check_word(input string name, input pov_display_pkg::driver_word_t got,
                              input pov_display_pkg::driver_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h (at %0t)", name, got, exp, $time);
        end
    endtask

    task automatic check_columns(input pov_display_pkg::column_mask_t got,
                                 input pov_display_pkg::column_mask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch column_sel: got %h expected %h (at %0t)", got, exp, $time);
        end
    endtask

    task automatic check_rotation(input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch spi_miso rotation: got %h expected %h (at %0t)", got, exp, $time);
        end
    endtask

    task automatic check_half_period(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("mismatch drv.gclk half period: got %h expected %h (at %0t)",
                     got, exp, $time);
        end
    endtask

    // Mode 0 host, MISO sampled just before each rising sclk
    task automatic spi_transfer(input int nbytes);
        logic [7:0] b;
        spi_cs_n = 1'b0;
        repeat (SPI_HALF) @(negedge clk);
        for (int k = 0; k < nbytes; k++) begin
            b = tx_bytes[k];
            for (int j = 7; j >= 0; j--) begin
                spi_mosi = b[j];
                repeat (SPI_HALF) @(negedge clk);
                miso_bits = {miso_bits[62:0], spi_miso};
                spi_sclk  = 1'b1;
                repeat (SPI_HALF) @(negedge clk);
                spi_sclk  = 1'b0;
            end
        end
        repeat (SPI_HALF) @(negedge clk);
        spi_cs_n = 1'b1;
        // Sync, strobe, decode and buffer write
        repeat (12) @(negedge clk);
    endtask

    task automatic write_column(input int idx, input pov_display_pkg::driver_word_t word);
        tx_bytes[0] = pov_display_pkg::WRITE_COLUMN;
        tx_bytes[1] = 8'(idx);
        for (int b = 0; b < WORD_BYTES; b++) begin
            tx_bytes[2 + b] = word[W-1-8*b -: 8];
        end
        spi_transfer(WORD_BYTES + 2);
        model_words[idx] = word;
    endtask

    task automatic write_config(input pov_display_pkg::driver_word_t word);
        tx_bytes[0] = pov_display_pkg::WRITE_CONFIG;
        for (int b = 0; b < WORD_BYTES; b++) begin
            tx_bytes[1 + b] = word[W-1-8*b -: 8];
        end
        spi_transfer(WORD_BYTES + 1);
        model_cfg     = word;
        model_pending = 1'b1;
    endtask

    task automatic pulse_position();
        position_sync = 1'b1;
        @(negedge clk);
        position_sync = 1'b0;
    endtask

    // Frames recorded, then pointer update and return to IDLE
    task automatic wait_frames(input int n);
        while (got_lat.size() < n) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic expect_frame(input logic is_cfg);
        pov_display_pkg::driver_word_t got;
        pov_display_pkg::driver_word_t exp;
        int bits;
        int lat;
        int exp_lat;
        if (got_lat.size() == 0) begin
            note_failure("expected a latched driver frame but none was seen");
            return;
        end
        bits    = got_bits.pop_front();
        lat     = got_lat.pop_front();
        exp_lat = (is_cfg ? `POV_CFG_LATCH_TICKS : 1) * `POV_SHIFT_DIV;
        for (int i = 0; i < ND; i++) begin
            got = got_words.pop_front();
            exp = is_cfg ? model_cfg : model_words[i];
            check_word($sformatf("drv.sin[%0d] word", i), got, exp);
        end
        if (bits != W) begin
            note_failure($sformatf("frame had %0d sclk pulses instead of %0d", bits, W));
        end
        if (lat != exp_lat) begin
            note_failure($sformatf("latch lasted %0d cycles instead of %0d", lat, exp_lat));
        end
        // Config goes out once, column moves on after every data latch
        if (is_cfg) begin
            model_pending = 1'b0;
        end else begin
            model_col = (model_col + 1) % NC;
        end
    endtask

    task automatic reset_and_first_frame();
        check_columns(column_sel, '0);
        if (drv.lat !== 1'b0 || drv.sclk !== 1'b0) begin
            note_failure("lat or sclk not low after reset");
        end
        pulse_position();
        wait_frames(1);
        expect_frame(1'b0);
        check_columns(column_sel, expected_columns());
    endtask

    task automatic column_write_rounds();
        logic [31:0] r;
        for (int round = 0; round < WRITE_ROUNDS; round++) begin
            for (int k = 0; k < ND; k++) begin
                r = next_rand();
                write_column(int'(r[31:24]) % ND, rand_word());
            end
            pulse_position();
            wait_frames(1);
            expect_frame(1'b0);
        end
    endtask

    task automatic config_then_data();
        write_config(rand_word());
        pulse_position();
        wait_frames(2);
        expect_frame(model_pending);
        expect_frame(1'b0);
        // Config already taken, plain data frame only
        pulse_position();
        wait_frames(1);
        expect_frame(model_pending);
    endtask

    task automatic mask_rotation();
        logic [31:0] r;
        r = next_rand();
        model_mask  = r[31:24] | 8'h01;
        tx_bytes[0] = pov_display_pkg::SET_MUX;
        tx_bytes[1] = model_mask;
        spi_transfer(2);
        check_columns(column_sel, expected_columns());
        for (int f = 0; f < MUX_FRAMES; f++) begin
            pulse_position();
            wait_frames(1);
            expect_frame(1'b0);
            check_columns(column_sel, expected_columns());
        end
    endtask

    task automatic rotation_readback();
        logic [31:0] r;
        for (int k = 0; k < ROT_READS; k++) begin
            r           = next_rand();
            rotation    = r[31:16];
            tx_bytes[0] = pov_display_pkg::READ_ROTATION;
            tx_bytes[1] = 8'h00;
            tx_bytes[2] = 8'h00;
            spi_transfer(3);
            check_rotation(miso_bits[15:0], r[31:16]);
        end
    endtask

    task automatic pulse_burst();
        logic [31:0] r;
        int gap;
        int since;
        int accepted;
        since    = 0;
        accepted = 0;
        for (int p = 0; p < BURST_PULSES; p++) begin
            if (p > 0) begin
                r   = next_rand();
                gap = 20 + int'(r[31:8] % 280);
                // Keep clear of the exact frame boundary
                if (since + gap > FRAME_CYCLES - 4 && since + gap < FRAME_CYCLES + 4) begin
                    gap += 8;
                end
                repeat (gap - 1) @(negedge clk);
                since += gap;
            end
            if (p == 0 || since >= FRAME_CYCLES) begin
                accepted++;
                since = 0;
            end
            pulse_position();
        end
        wait_frames(accepted);
        repeat (FRAME_CYCLES) @(negedge clk);
        if (got_lat.size() != accepted) begin
            note_failure($sformatf("%0d frames latched for %0d accepted pulses",
                                   got_lat.size(), accepted));
        end
        for (int f = 0; f < accepted; f++) begin
            expect_frame(1'b0);
        end
        check_columns(column_sel, expected_columns());
    endtask

    initial begin
        rng_state     = 32'hed2a46a8;
        checks        = 0;
        errors        = 0;
        cycle_count   = 0;
        miso_bits     = '0;
        rst_n         = 1'b0;
        spi_sclk      = 1'b0;
        spi_cs_n      = 1'b1;
        spi_mosi      = 1'b0;
        rotation      = '0;
        position_sync = 1'b0;
        model_cfg     = '0;
        model_pending = 1'b0;
        model_mask    = '0;
        model_col     = 0;
        for (int i = 0; i < ND; i++) begin
            model_words[i] = '0;
            cap_word[i]    = '0;
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        reset_and_first_frame();
        column_write_rounds();
        config_then_data();
        mask_rotation();
        rotation_readback();
        pulse_burst();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== pov_display.f ====
+incdir+rtl
rtl/pov_display_pkg.sv
rtl/spi_command_receiver.sv
rtl/command_decoder.sv
rtl/column_buffer.sv
rtl/driver_sequencer.sv
rtl/shift_timer.sv
rtl/column_selector.sv
rtl/pov_display_top.sv
verification/pov_display_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pov_display_tb \
    -f pov_display.f -Mdir obj_dir -o pov_display_sim

out=$(./obj_dir/pov_display_sim)
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
else
    exit 1
fi
